//--- flist.f
+incdir+hdl
hdl/bp_pkg.sv
hdl/bp_if.sv
hdl/branch_target_buffer.sv
hdl/gshare_predictor.sv
hdl/bp_predict_stage.sv
hdl/pred_queue.sv
hdl/bp_resolve_stage.sv
hdl/bp_unit.sv
testbench/bp_unit_tb.sv

//--- Makefile
# Verilator build and run for the branch prediction unit testbench

VERILATOR ?= verilator
TOP       ?= bp_unit_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FLIST)))
HEADERS := $(wildcard hdl/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuild only when a source, a header or the file list changes
$(SIM): $(FLIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/bp_unit_tests.txt
# fetch pc exp_taken exp_target | burst start_pc cycles exp_accepted | ready exp_ready | reset
# resolve op taken target exp_mispredict exp_redirect_pc (all fields hex)
# Cold tables, everything falls through
fetch 00001000 0 00001004
fetch 00001004 0 00001008
resolve 13 0 00000000 0 00001004
resolve 13 0 00000000 0 00001008
# Jal misses once, then hits
fetch 00001010 0 00001014
resolve 6f 1 00002000 1 00002000
fetch 00001010 1 00002000
resolve 6f 1 00002000 0 00002000
# Same index as the jal, other tag
fetch 00001090 0 00001094
resolve 13 0 00000000 0 00001094
fetch 00001010 1 00002000
resolve 6f 1 00002000 0 00002000
# Queue fills after four, one resolve frees a credit a cycle later
burst 00003000 6 4
resolve 63 1 00003100 1 00003100
ready 0
ready 1
resolve 63 1 00003100 1 00003100
resolve 63 1 00003100 1 00003100
resolve 63 1 00003100 1 00003100
fetch 00003010 0 00003014
resolve 63 1 00003100 1 00003100
# History is all ones now, so two taken outcomes keep it there
fetch 00001020 0 00001024
fetch 00001020 0 00001024
resolve 63 1 00001100 1 00001100
resolve 63 1 00001100 1 00001100
fetch 00001020 1 00001100
fetch 00001020 1 00001100
resolve 63 0 00000000 1 00001024
resolve 63 0 00000000 1 00001024
fetch 00001020 0 00001100
resolve 63 0 00000000 0 00001024
# Reset forgets what was learned
reset
fetch 00001020 0 00001024
fetch 00001010 0 00001014
resolve 13 0 00000000 0 00001024
resolve 13 0 00000000 0 00001014

//--- testbench/bp_unit_tb.sv
// Self-checking testbench for the branch prediction unit, run from the project root
module bp_unit_tb;

    // Cycles allowed per line of the command file before the watchdog stops the run
    localparam int CYCLES_PER_LINE = 64;
    localparam string TEST_FILE = "testbench/bp_unit_tests.txt";

    // Command words are read as packed text, right aligned
    typedef logic [8*16-1:0] word_t;

    logic           clk = 1'b0;
    logic           reset_i;
    logic           fetch_valid_i;
    logic [31:0]    fetch_pc_i;
    logic           fetch_ready_o;
    logic           pred_valid_o;
    logic           pred_taken_o;
    logic [31:0]    pred_target_o;
    logic           res_valid_i;
    logic [6:0]     res_op_i;
    logic           res_taken_i;
    logic [31:0]    res_target_i;
    logic           redirect_valid_o;
    logic           mispredict_o;
    logic [31:0]    redirect_pc_o;

    int error_count     = 0;
    int check_count     = 0;
    int line_count      = 0;
    int watchdog_cycles = 0;
    int fd;

    bp_unit uut (
        .clk              (clk),
        .reset_i          (reset_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_ready_o    (fetch_ready_o),
        .pred_valid_o     (pred_valid_o),
        .pred_taken_o     (pred_taken_o),
        .pred_target_o    (pred_target_o),
        .res_valid_i      (res_valid_i),
        .res_op_i         (res_op_i),
        .res_taken_i      (res_taken_i),
        .res_target_i     (res_target_i),
        .redirect_valid_o (redirect_valid_o),
        .mispredict_o     (mispredict_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    // Period of 4, rising edges at 2, 6, 10 and so on
    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error at time %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic note_failure(input string msg);
        error_count++;
        $display("failure at time %0t: %s", $time, msg);
    endtask

    // Holds reset for two rising edges, then checks the idle state at the next falling edge
    task automatic apply_reset();
        reset_i       = 1'b1;
        fetch_valid_i = 1'b0;
        res_valid_i   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;
        @(negedge clk);
        check_value("fetch_ready_o", 32'(fetch_ready_o), 32'd1);
        check_value("pred_valid_o", 32'(pred_valid_o), 32'd0);
        check_value("redirect_valid_o", 32'(redirect_valid_o), 32'd0);
        check_value("mispredict_o", 32'(mispredict_o), 32'd0);
        @(posedge clk);
        #1;
    endtask

    // Offers one PC until it is taken, the prediction must show one cycle later
    task automatic run_fetch(input logic [31:0] pc, input logic [31:0] exp_taken,
                             input logic [31:0] exp_target);
        logic accepted;
        accepted      = 1'b0;
        fetch_valid_i = 1'b1;
        fetch_pc_i    = pc;
        while (!accepted) begin
            @(negedge clk);
            accepted = fetch_ready_o;
            @(posedge clk);
            #1;
        end
        fetch_valid_i = 1'b0;
        @(negedge clk);
        check_value("pred_valid_o", 32'(pred_valid_o), 32'd1);
        check_value("pred_taken_o", 32'(pred_taken_o), exp_taken);
        check_value("pred_target_o", pred_target_o, exp_target);
        @(posedge clk);
        #1;
    endtask

    // Keeps fetch_valid_i high for a fixed number of cycles and steps the PC on each accept
    // Burst PCs are never learned, so each prediction falls through to PC+4
    task automatic run_burst(input logic [31:0] start_pc, input logic [31:0] cycles,
                             input logic [31:0] exp_accepted);
        logic [31:0] pc;
        logic [31:0] last_pc;
        logic [31:0] accepted;
        logic [31:0] cycle;
        logic        pending;
        pc       = start_pc;
        last_pc  = start_pc;
        accepted = '0;
        pending  = 1'b0;
        for (cycle = '0; cycle < cycles; cycle++) begin
            fetch_valid_i = 1'b1;
            fetch_pc_i    = pc;
            @(negedge clk);
            // The fetch taken in the previous cycle shows up now, in order
            check_value("pred_valid_o", 32'(pred_valid_o), 32'(pending));
            if (pending) begin
                check_value("pred_taken_o", 32'(pred_taken_o), 32'd0);
                check_value("pred_target_o", pred_target_o, last_pc + 32'd4);
            end
            pending = fetch_ready_o;
            if (fetch_ready_o) begin
                last_pc  = pc;
                pc       = pc + 32'd4;
                accepted = accepted + 32'd1;
            end
            @(posedge clk);
            #1;
        end
        fetch_valid_i = 1'b0;
        @(negedge clk);
        check_value("pred_valid_o", 32'(pred_valid_o), 32'(pending));
        if (pending) begin
            check_value("pred_taken_o", 32'(pred_taken_o), 32'd0);
            check_value("pred_target_o", pred_target_o, last_pc + 32'd4);
        end
        check_value("burst accepted fetches", accepted, exp_accepted);
        @(posedge clk);
        #1;
    endtask

    // Redirect outputs are combinational from the queue head, so they are read mid-cycle
    task automatic run_resolve(input logic [31:0] op, input logic [31:0] taken,
                               input logic [31:0] target, input logic [31:0] exp_mispredict,
                               input logic [31:0] exp_redirect);
        res_valid_i  = 1'b1;
        res_op_i     = op[6:0];
        res_taken_i  = taken[0];
        res_target_i = target;
        @(negedge clk);
        check_value("redirect_valid_o", 32'(redirect_valid_o), 32'd1);
        check_value("mispredict_o", 32'(mispredict_o), exp_mispredict);
        check_value("redirect_pc_o", redirect_pc_o, exp_redirect);
        @(posedge clk);
        #1;
        res_valid_i = 1'b0;
    endtask

    task automatic check_ready(input logic [31:0] exp_ready);
        @(negedge clk);
        check_value("fetch_ready_o", 32'(fetch_ready_o), exp_ready);
        @(posedge clk);
        #1;
    endtask

    // Newlines in the command file set the watchdog budget
    task automatic count_lines();
        int ch;
        int cfd;
        cfd = $fopen(TEST_FILE, "r");
        if (cfd != 0) begin
            ch = $fgetc(cfd);
            while (ch != -1) begin
                if (ch == 10) begin
                    line_count++;
                end
                ch = $fgetc(cfd);
            end
            $fclose(cfd);
        end
    endtask

    task automatic run_file();
        word_t            cmd;
        logic [8*256-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [31:0]      d;
        logic [31:0]      e;
        int               rc;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == word_t'("#")) begin
                rc = $fgets(rest, fd);
            end else if (cmd == word_t'("reset")) begin
                apply_reset();
            end else if (cmd == word_t'("fetch")) begin
                rc = $fscanf(fd, "%h %h %h", a, b, c);
                if (rc != 3) begin
                    note_failure("a fetch line in the test file has missing fields");
                end else begin
                    run_fetch(a, b, c);
                end
            end else if (cmd == word_t'("burst")) begin
                rc = $fscanf(fd, "%h %h %h", a, b, c);
                if (rc != 3) begin
                    note_failure("a burst line in the test file has missing fields");
                end else begin
                    run_burst(a, b, c);
                end
            end else if (cmd == word_t'("resolve")) begin
                rc = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                if (rc != 5) begin
                    note_failure("a resolve line in the test file has missing fields");
                end else begin
                    run_resolve(a, b, c, d, e);
                end
            end else if (cmd == word_t'("ready")) begin
                rc = $fscanf(fd, "%h", a);
                if (rc != 1) begin
                    note_failure("a ready line in the test file has no expected value");
                end else begin
                    check_ready(a);
                end
            end else begin
                note_failure($sformatf("unknown command %0s in the test file", cmd));
            end
        end
    endtask

    initial begin
        reset_i       = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        res_valid_i   = 1'b0;
        res_op_i      = '0;
        res_taken_i   = 1'b0;
        res_target_i  = '0;
        count_lines();
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s, so no tests were run", TEST_FILE);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            watchdog_cycles = line_count * CYCLES_PER_LINE;
            apply_reset();
            run_file();
            $fclose(fd);
            $display("checks %0d, errors %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

    // Stops a run that is stuck waiting on a handshake
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("checks %0d, errors %0d", check_count, error_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- hdl/bp_unit.sv
// Top level of the branch prediction unit, fed by fetch and execute through plain ports
module bp_unit (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               fetch_valid_i,
    input  bp_pkg::pc_t        fetch_pc_i,
    output logic               fetch_ready_o,
    output logic               pred_valid_o,
    output logic               pred_taken_o,
    output bp_pkg::pc_t        pred_target_o,
    input  logic               res_valid_i,
    input  bp_pkg::op_t        res_op_i,
    input  logic               res_taken_i,
    input  bp_pkg::pc_t        res_target_i,
    output logic               redirect_valid_o,
    output logic               mispredict_o,
    output bp_pkg::pc_t        redirect_pc_o
);

    // Predict to queue, then queue head to resolve
    pred_if   issue_bus ();
    pred_if   head_bus ();
    update_if train_bus ();

    logic pop;

    bp_predict_stage u_predict (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_ready_o (fetch_ready_o),
        .pred          (issue_bus),
        .upd           (train_bus)
    );

    pred_queue u_queue (
        .clk     (clk),
        .reset_i (reset_i),
        .in      (issue_bus),
        .out     (head_bus),
        .pop_i   (pop)
    );

    bp_resolve_stage u_resolve (
        .res_valid_i      (res_valid_i),
        .res_op_i         (res_op_i),
        .res_taken_i      (res_taken_i),
        .res_target_i     (res_target_i),
        .head             (head_bus),
        .pop_o            (pop),
        .upd              (train_bus),
        .redirect_valid_o (redirect_valid_o),
        .mispredict_o     (mispredict_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    // Fetch sees each prediction as it enters the queue
    assign pred_valid_o  = issue_bus.valid;
    assign pred_taken_o  = issue_bus.taken;
    assign pred_target_o = issue_bus.target;

endmodule

//--- hdl/bp_resolve_stage.sv
// Resolve stage that checks execute outcomes against the queue head and trains the tables
`include "bp_consts.svh"

module bp_resolve_stage (
    input  logic               res_valid_i,
    input  bp_pkg::op_t        res_op_i,
    input  logic               res_taken_i,
    input  bp_pkg::pc_t        res_target_i,
    pred_if.consumer           head,
    output logic               pop_o,
    update_if.source           upd,
    output logic               redirect_valid_o,
    output logic               mispredict_o,
    output bp_pkg::pc_t        redirect_pc_o
);

    logic          resolve;
    logic          is_branch;
    logic          is_jump;
    logic          dir_wrong;
    logic          target_wrong;
    bp_pkg::pc_t   seq_pc;

    // Only act while an unresolved prediction is waiting
    assign resolve = res_valid_i && head.valid;

    assign is_branch = (res_op_i == `BP_OP_BRANCH);
    assign is_jump   = (res_op_i == `BP_OP_JAL) || (res_op_i == `BP_OP_JALR);

    assign seq_pc = head.pc + 32'd4;

    // Direction error, or both taken but to different places
    assign dir_wrong    = (head.taken != res_taken_i);
    assign target_wrong = head.taken && res_taken_i && (head.target != res_target_i);

    assign pop_o            = resolve;
    assign redirect_valid_o = resolve;
    assign mispredict_o     = resolve && (dir_wrong || target_wrong);

    // Real next PC of the resolved instruction
    assign redirect_pc_o = res_taken_i ? res_target_i : seq_pc;

    // Counter and history train on conditional branches only
    assign upd.pht_we   = resolve && is_branch;
    assign upd.pht_idx  = head.pht_idx;
    assign upd.pht_inc  = res_taken_i;
    assign upd.hist_we  = resolve && is_branch;
    assign upd.hist_bit = res_taken_i;

    // Install or fix a target only when control actually left the sequential path
    always_comb begin
        upd.btb_we = 1'b0;
        if (resolve && res_taken_i && (is_branch || is_jump)) begin
            if (!head.hit || (head.target != res_target_i)) begin
                upd.btb_we = 1'b1;
            end
        end
    end

    assign upd.btb_pc        = head.pc;
    assign upd.btb_target    = res_target_i;
    assign upd.btb_is_jump   = is_jump;
    assign upd.btb_is_branch = is_branch;

endmodule

//--- hdl/pred_queue.sv
// In-order FIFO of in-flight predictions between the predict and resolve stages
`include "bp_consts.svh"

module pred_queue (
    input  logic        clk,
    input  logic        reset_i,
    pred_if.queue       in,
    pred_if.producer    out,
    input  logic        pop_i
);

    localparam int PTR_W = $clog2(`BP_QUEUE_DEPTH);

    bp_pkg::pc_t   pc_q     [`BP_QUEUE_DEPTH];
    bp_pkg::ghr_t  idx_q    [`BP_QUEUE_DEPTH];
    logic          hit_q    [`BP_QUEUE_DEPTH];
    logic          taken_q  [`BP_QUEUE_DEPTH];
    bp_pkg::pc_t   target_q [`BP_QUEUE_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    bp_pkg::credit_t  count_q;
    logic             credit_q;

    // Wraps at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`BP_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Credits guarantee a free slot on every push
    always_ff @(posedge clk) begin
        if (reset_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            if (in.valid) begin
                tail_q <= next_ptr(tail_q);
            end
            if (pop_i) begin
                head_q <= next_ptr(head_q);
            end
            if (in.valid && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (!in.valid && pop_i) begin
                count_q <= count_q - 1'b1;
            end
            // Slot freed this cycle goes back as a credit one cycle later
            credit_q <= pop_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            pc_q[tail_q]     <= in.pc;
            idx_q[tail_q]    <= in.pht_idx;
            hit_q[tail_q]    <= in.hit;
            taken_q[tail_q]  <= in.taken;
            target_q[tail_q] <= in.target;
        end
    end

    assign in.credit_return = credit_q;

    // Head entry is shown as soon as the queue holds anything
    assign out.valid   = (count_q != '0);
    assign out.pc      = pc_q[head_q];
    assign out.pht_idx = idx_q[head_q];
    assign out.hit     = hit_q[head_q];
    assign out.taken   = taken_q[head_q];
    assign out.target  = target_q[head_q];

endmodule

//--- hdl/bp_predict_stage.sv
// Predict stage that looks up each accepted fetch PC and issues a registered prediction
`include "bp_consts.svh"

module bp_predict_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               fetch_valid_i,
    input  bp_pkg::pc_t        fetch_pc_i,
    output logic               fetch_ready_o,
    pred_if.producer           pred,
    update_if.sink             upd
);

    logic             accept;
    logic             btb_hit;
    logic             btb_jump;
    logic             btb_branch;
    bp_pkg::pc_t      btb_target;
    bp_pkg::ghr_t     gs_idx;
    logic             gs_taken;
    logic             next_taken;
    bp_pkg::pc_t      next_target;

    // Issued prediction, held in registers for one cycle
    logic             valid_q;
    bp_pkg::pc_t      pc_q;
    bp_pkg::ghr_t     idx_q;
    logic             hit_q;
    logic             taken_q;
    bp_pkg::pc_t      target_q;

    // One credit per free queue slot
    bp_pkg::credit_t  credits_q;

    branch_target_buffer u_btb (
        .clk         (clk),
        .reset_i     (reset_i),
        .lookup_pc_i (fetch_pc_i),
        .hit_o       (btb_hit),
        .is_jump_o   (btb_jump),
        .is_branch_o (btb_branch),
        .target_o    (btb_target),
        .upd         (upd)
    );

    gshare_predictor u_gshare (
        .clk             (clk),
        .reset_i         (reset_i),
        .lookup_pc_i     (fetch_pc_i),
        .pht_idx_o       (gs_idx),
        .predict_taken_o (gs_taken),
        .upd             (upd)
    );

    assign fetch_ready_o = (credits_q != '0);
    assign accept        = fetch_valid_i && fetch_ready_o;

    // Jumps always go, branches follow the counter, anything unknown falls through
    always_comb begin
        if (btb_hit && btb_jump) begin
            next_taken  = 1'b1;
            next_target = btb_target;
        end else if (btb_hit && btb_branch) begin
            next_taken  = gs_taken;
            next_target = btb_target;
        end else begin
            next_taken  = 1'b0;
            next_target = fetch_pc_i + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q     <= fetch_pc_i;
            idx_q    <= gs_idx;
            hit_q    <= btb_hit;
            taken_q  <= next_taken;
            target_q <= next_target;
        end
    end

    // A push and a returned credit in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (reset_i) begin
            credits_q <= bp_pkg::credit_t'(`BP_QUEUE_DEPTH);
        end else if (accept && !pred.credit_return) begin
            credits_q <= credits_q - 1'b1;
        end else if (!accept && pred.credit_return) begin
            credits_q <= credits_q + 1'b1;
        end
    end

    assign pred.valid   = valid_q;
    assign pred.pc      = pc_q;
    assign pred.pht_idx = idx_q;
    assign pred.hit     = hit_q;
    assign pred.taken   = taken_q;
    assign pred.target  = target_q;

endmodule

//--- hdl/gshare_predictor.sv
// Gshare direction predictor holding the pattern history table and the global history
`include "bp_consts.svh"

module gshare_predictor (
    input  logic               clk,
    input  logic               reset_i,
    input  bp_pkg::pc_t        lookup_pc_i,
    output bp_pkg::ghr_t       pht_idx_o,
    output logic               predict_taken_o,
    update_if.sink             upd
);

    localparam int PHT_ENTRIES = 2 ** `BP_GHR_BITS;

    bp_pkg::ctr_t pht_q [PHT_ENTRIES];
    bp_pkg::ghr_t ghr_q;

    bp_pkg::ctr_t upd_cur;
    bp_pkg::ctr_t upd_next;

    // Low word-address bits hashed with the history
    assign pht_idx_o       = lookup_pc_i[`BP_GHR_BITS+1:2] ^ ghr_q;
    assign predict_taken_o = pht_q[pht_idx_o][1];

    // Saturating step of the counter being trained
    assign upd_cur = pht_q[upd.pht_idx];

    always_comb begin
        upd_next = upd_cur;
        if (upd.pht_inc) begin
            if (upd_cur != 2'b11) begin
                upd_next = upd_cur + 2'b01;
            end
        end else begin
            if (upd_cur != 2'b00) begin
                upd_next = upd_cur - 2'b01;
            end
        end
    end

    // All counters start weakly not taken
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (upd.pht_we) begin
            pht_q[upd.pht_idx] <= upd_next;
        end
    end

    // History moves only at resolution, newest outcome lands in the LSB
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
        end else if (upd.hist_we) begin
            ghr_q <= {ghr_q[`BP_GHR_BITS-2:0], upd.hist_bit};
        end
    end

endmodule

//--- hdl/branch_target_buffer.sv
// Direct-mapped branch target buffer with full-PC tags, looked up by the predict stage
`include "bp_consts.svh"

module branch_target_buffer (
    input  logic               clk,
    input  logic               reset_i,
    input  bp_pkg::pc_t        lookup_pc_i,
    output logic               hit_o,
    output logic               is_jump_o,
    output logic               is_branch_o,
    output bp_pkg::pc_t        target_o,
    update_if.sink             upd
);

    localparam int IDX_W = $bits(bp_pkg::btb_idx_t);

    // Entry payload, only meaningful where the valid bit is set
    bp_pkg::pc_t tag_q    [`BP_BTB_ENTRIES];
    bp_pkg::pc_t target_q [`BP_BTB_ENTRIES];
    logic        jump_q   [`BP_BTB_ENTRIES];
    logic        branch_q [`BP_BTB_ENTRIES];

    // One valid bit per entry
    logic [`BP_BTB_ENTRIES-1:0] valid_q;

    bp_pkg::btb_idx_t rd_idx;
    bp_pkg::btb_idx_t wr_idx;

    // Instructions are word aligned so bits 1:0 are skipped
    assign rd_idx = lookup_pc_i[IDX_W+1:2];
    assign wr_idx = upd.btb_pc[IDX_W+1:2];

    // The whole PC is kept as tag, so aliasing PCs never hit each other
    assign hit_o       = valid_q[rd_idx] && (tag_q[rd_idx] == lookup_pc_i);
    assign is_jump_o   = jump_q[rd_idx];
    assign is_branch_o = branch_q[rd_idx];
    assign target_o    = target_q[rd_idx];

    // Valid bits clear on reset and set on each write
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (upd.btb_we) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // A write replaces the whole entry at the resolved PC's index
    always_ff @(posedge clk) begin
        if (upd.btb_we) begin
            tag_q[wr_idx]    <= upd.btb_pc;
            target_q[wr_idx] <= upd.btb_target;
            jump_q[wr_idx]   <= upd.btb_is_jump;
            branch_q[wr_idx] <= upd.btb_is_branch;
        end
    end

endmodule

//--- hdl/bp_if.sv
// Prediction and table update buses that link the predict, queue and resolve stages

// One prediction per cycle at most, plus a credit pulse flowing the other way
interface pred_if;

    logic            valid;
    bp_pkg::pc_t     pc;
    bp_pkg::ghr_t    pht_idx;
    logic            hit;
    logic            taken;
    bp_pkg::pc_t     target;
    logic            credit_return;

    // Side that issues predictions and gets credits back
    modport producer (
        output valid, pc, pht_idx, hit, taken, target,
        input  credit_return
    );

    // Receiving side of the queue, which hands a credit back per freed slot
    modport queue (
        input  valid, pc, pht_idx, hit, taken, target,
        output credit_return
    );

    // Resolve stage only looks at the head entry
    modport consumer (
        input valid, pc, pht_idx, hit, taken, target
    );

endinterface

// Table write commands from the resolve stage back to the lookup tables
interface update_if;

    logic            btb_we;
    bp_pkg::pc_t     btb_pc;
    bp_pkg::pc_t     btb_target;
    logic            btb_is_jump;
    logic            btb_is_branch;
    logic            pht_we;
    bp_pkg::ghr_t    pht_idx;
    logic            pht_inc;
    logic            hist_we;
    logic            hist_bit;

    modport source (
        output btb_we, btb_pc, btb_target, btb_is_jump, btb_is_branch,
        output pht_we, pht_idx, pht_inc, hist_we, hist_bit
    );

    modport sink (
        input btb_we, btb_pc, btb_target, btb_is_jump, btb_is_branch,
        input pht_we, pht_idx, pht_inc, hist_we, hist_bit
    );

endinterface

//--- hdl/bp_pkg.sv
// Vector types shared by all branch predictor stages, referenced by scoped names
`include "bp_consts.svh"

package bp_pkg;

    // Program counter or branch target, full RV32 width
    typedef logic [31:0] pc_t;

    // Major opcode field of an RV32 instruction
    typedef logic [6:0] op_t;

    // Target buffer index, taken from the PC bits just above the byte offset
    typedef logic [$clog2(`BP_BTB_ENTRIES)-1:0] btb_idx_t;

    // Global history register
    // The same width indexes the pattern history table
    typedef logic [`BP_GHR_BITS-1:0] ghr_t;

    // Two-bit saturating counter
    // MSB set means predict taken
    typedef logic [1:0] ctr_t;

    // Credit count, must hold every value from zero to the queue depth
    typedef logic [$clog2(`BP_QUEUE_DEPTH+1)-1:0] credit_t;

endpackage

//--- hdl/bp_consts.svh
// Table sizes, queue depth and RV32 opcodes for the branch predictor, included by RTL and package
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Number of direct-mapped target buffer entries, a power of two
`define BP_BTB_ENTRIES 32

// Global history length, which is also the counter table index width
`define BP_GHR_BITS 5

// Number of in-flight predictions and the credits the predict stage starts with
`define BP_QUEUE_DEPTH 4

// RV32 base opcodes of control-flow instructions
`define BP_OP_BRANCH 7'b1100011
`define BP_OP_JAL 7'b1101111
`define BP_OP_JALR 7'b1100111

`endif
